// File: hdl/game_pkg.sv
`default_nettype none

package game_pkg;

	// screen coordinate widths, same as the vga side
	localparam int x_width = 9;
	localparam int y_width = 8;

	// play field, border ring is wall
	localparam int field_w = 16;
	localparam int field_h = 12;
	localparam int sprite_size = 2; // solid square sprites

	typedef logic [5:0] colour_t; // 2 bits per channel
	localparam colour_t wall_colour = 6'h15;
	localparam colour_t floor_colour = 6'h02;
	localparam colour_t player_colour = 6'h0c;
	localparam colour_t enemy_colour = 6'h30;

	// player action, also reused for facing
	typedef enum logic [2:0] {
		act_none = 3'b000,
		act_attack = 3'b001,
		act_up = 3'b010,
		act_down = 3'b011,
		act_left = 3'b100,
		act_right = 3'b101
	} action_t;

	localparam logic [x_width-1:0] player_start_x = 9'd2;
	localparam logic [y_width-1:0] player_start_y = 8'd2;
	localparam logic [x_width-1:0] enemy_start_x = 9'd12; // also the respawn point
	localparam logic [y_width-1:0] enemy_start_y = 8'd8;

	localparam int frame_ticks = 64; // idle cycles per frame, kept short for sim

endpackage

`default_nettype wire

// File: hdl/game_control.sv
`timescale 1ns/10ps
`default_nettype none

module game_control
(
	input logic clock,
	input logic reset,
	input logic idle_done, // frame period over
	input logic map_done,
	input logic player_done,
	input logic enemy_done,
	output logic init,
	output logic idle,
	output logic gen_move,
	output logic check_collide,
	output logic apply_action,
	output logic move_enemy,
	output logic draw_map,
	output logic draw_player,
	output logic draw_enemy
);

	logic [8:0] state; // one-hot, bit 0 init .. bit 8 draw_enemy
	logic advance; // current phase is finished

	// strobes come straight off the state bits
	assign {draw_enemy, draw_player, draw_map, move_enemy, apply_action,
		check_collide, gen_move, idle, init} = state;

	// single-cycle phases always move on
	assign advance = init || gen_move || check_collide || apply_action || move_enemy
		|| (idle && idle_done)
		|| (draw_map && map_done) // draw phases wait for their drawer
		|| (draw_player && player_done)
		|| (draw_enemy && enemy_done);

	always_ff @(posedge clock)
	begin
		if (reset)
			state <= 9'b0_0000_0001; // start in init
		else if (advance)
			state <= {state[7:1], state[8] | state[0], 1'b0}; // init and draw_enemy both go to idle
	end

	// one phase at a time, otherwise two drawers could fight over the pixel port
	assert property (@(posedge clock) disable iff (reset) $onehot(state));

endmodule

`default_nettype wire

// File: hdl/frame_timer.sv
`timescale 1ns/10ps
`default_nettype none

module frame_timer import game_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic init,
	input logic idle,
	output logic idle_done
);

	logic [$clog2(frame_ticks+1)-1:0] count; // idle cycles seen so far

	// fires on the last idle cycle, drops as soon as idle ends
	assign idle_done = idle && (count == frame_ticks[$bits(count)-1:0]);

	always_ff @(posedge clock)
	begin
		if (reset || init || !idle || idle_done)
			count <= '0; // each idle period starts from zero
		else
			count <= count + 1'b1;
	end

endmodule

`default_nettype wire

// File: hdl/map_drawer.sv
`timescale 1ns/10ps
`default_nettype none

module map_drawer import game_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic draw_map,
	input logic grant,
	output logic req,
	output logic [x_width-1:0] x,
	output logic [y_width-1:0] y,
	output colour_t colour,
	output logic map_done
);

	logic border; // current pixel is on the wall ring
	logic last_col;
	logic last_row;

	assign last_col = (x == field_w - 1);
	assign last_row = (y == field_h - 1);
	assign border = (x == 0) || (y == 0) || last_col || last_row;

	assign req = draw_map && !map_done; // pixels left while not done
	assign colour = border ? wall_colour : floor_colour;

	always_ff @(posedge clock)
	begin
		if (reset || !draw_map)
		begin
			x <= '0;
			y <= '0;
			map_done <= 1'b0;
		end
		else if (req && grant) // hold the pixel until granted
		begin
			if (last_col)
			begin
				x <= '0; // raster order, wrap to next row
				if (last_row)
					map_done <= 1'b1;
				else
					y <= y + 1'b1;
			end
			else
				x <= x + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: hdl/player_unit.sv
`timescale 1ns/10ps
`default_nettype none

module player_unit import game_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic init,
	input logic c_attack,
	input logic c_up,
	input logic c_down,
	input logic c_left,
	input logic c_right,
	input logic gen_move,
	input logic apply_action,
	input logic draw_player,
	input logic grant,
	input logic player_blocked,
	input logic attack_hit,
	output logic [x_width-1:0] player_x,
	output logic [y_width-1:0] player_y,
	output action_t action,
	output action_t facing,
	output logic [7:0] score,
	output logic req,
	output logic [x_width-1:0] x,
	output logic [y_width-1:0] y,
	output colour_t colour,
	output logic player_done
);

	action_t next_action; // decoded buttons
	logic [1:0] idx; // sprite pixel, bit 0 col, bit 1 row

	// button priority attack > up > down > left > right
	always_comb
	begin
		if (c_attack)
			next_action = act_attack;
		else if (c_up)
			next_action = act_up;
		else if (c_down)
			next_action = act_down;
		else if (c_left)
			next_action = act_left;
		else if (c_right)
			next_action = act_right;
		else
			next_action = act_none;
	end

	always_ff @(posedge clock)
	begin
		if (reset || init)
		begin
			player_x <= player_start_x;
			player_y <= player_start_y;
			action <= act_none;
			facing <= act_down;
			score <= '0;
		end
		else
		begin
			if (gen_move)
			begin
				action <= next_action;
				if (next_action != act_none && next_action != act_attack)
					facing <= next_action; // only moves turn the player
			end
			if (apply_action)
			begin
				if (attack_hit && score != 8'hff)
					score <= score + 1'b1; // saturates
				if (!player_blocked)
				begin
					case (action)
						act_up: player_y <= player_y - 1'b1;
						act_down: player_y <= player_y + 1'b1;
						act_left: player_x <= player_x - 1'b1;
						act_right: player_x <= player_x + 1'b1;
						default: ; // attack or idle, stay put
					endcase
				end
			end
		end
	end

	assign req = draw_player && !player_done;
	assign x = player_x + x_width'(idx[0]);
	assign y = player_y + y_width'(idx[1]);
	assign colour = player_colour;

	always_ff @(posedge clock)
	begin
		if (reset || !draw_player)
		begin
			idx <= '0;
			player_done <= 1'b0;
		end
		else if (req && grant)
		begin
			idx <= idx + 1'b1;
			if (idx == 2'd3)
				player_done <= 1'b1; // last of four pixels went out
		end
	end

	// wall checks in the detector must keep the whole sprite on floor
	assert property (@(posedge clock) disable iff (reset)
		player_x >= 1 && player_x <= field_w - sprite_size - 1
		&& player_y >= 1 && player_y <= field_h - sprite_size - 1);

endmodule

`default_nettype wire

// File: hdl/enemy_unit.sv
`timescale 1ns/10ps
`default_nettype none

module enemy_unit import game_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic init,
	input logic move_enemy,
	input logic draw_enemy,
	input logic grant,
	input logic enemy_block_x,
	input logic enemy_block_y,
	input logic attack_hit,
	input logic [x_width-1:0] player_x,
	input logic [y_width-1:0] player_y,
	output logic [x_width-1:0] enemy_x,
	output logic [y_width-1:0] enemy_y,
	output logic req,
	output logic [x_width-1:0] x,
	output logic [y_width-1:0] y,
	output colour_t colour,
	output logic enemy_done
);

	logic [1:0] idx; // sprite pixel counter

	always_ff @(posedge clock)
	begin
		if (reset || init)
		begin
			enemy_x <= enemy_start_x;
			enemy_y <= enemy_start_y;
		end
		else if (move_enemy)
		begin
			if (attack_hit)
			begin
				enemy_x <= enemy_start_x; // respawn
				enemy_y <= enemy_start_y;
			end
			else if (enemy_x != player_x && !enemy_block_x) // close x first
				enemy_x <= (enemy_x < player_x) ? enemy_x + 1'b1 : enemy_x - 1'b1;
			else if (enemy_y != player_y && !enemy_block_y)
				enemy_y <= (enemy_y < player_y) ? enemy_y + 1'b1 : enemy_y - 1'b1;
		end
	end

	assign req = draw_enemy && !enemy_done;
	assign x = enemy_x + x_width'(idx[0]);
	assign y = enemy_y + y_width'(idx[1]);
	assign colour = enemy_colour;

	// four pixels, row by row, stepping only on grant
	always_ff @(posedge clock)
	begin
		if (reset || !draw_enemy)
		begin
			idx <= '0;
			enemy_done <= 1'b0;
		end
		else if (req && grant)
		begin
			idx <= idx + 1'b1;
			if (idx == 2'd3)
				enemy_done <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: hdl/collision_detector.sv
`timescale 1ns/10ps
`default_nettype none

module collision_detector import game_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic check_collide,
	input logic [x_width-1:0] player_x,
	input logic [y_width-1:0] player_y,
	input action_t action,
	input action_t facing,
	input logic [x_width-1:0] enemy_x,
	input logic [y_width-1:0] enemy_y,
	output logic player_blocked,
	output logic enemy_block_x,
	output logic enemy_block_y,
	output logic attack_hit
);

	logic [x_width-1:0] px_next; // player origin after the move
	logic [y_width-1:0] py_next;
	logic [x_width-1:0] ex_next; // enemy origin after a step toward the player
	logic [y_width-1:0] ey_next;
	logic [x_width-1:0] dx; // player to enemy distance
	logic [y_width-1:0] dy;
	logic in_reach;

	// sprite with origin (sx, sy) overlaps the wall ring
	function automatic logic hits_wall(input logic [x_width-1:0] sx,
		input logic [y_width-1:0] sy);
		return sx == 0 || sx > field_w - sprite_size - 1
			|| sy == 0 || sy > field_h - sprite_size - 1;
	endfunction

	always_comb
	begin
		px_next = player_x;
		py_next = player_y;
		case (action)
			act_up: py_next = player_y - 1'b1;
			act_down: py_next = player_y + 1'b1;
			act_left: px_next = player_x - 1'b1;
			act_right: px_next = player_x + 1'b1;
			default: ; // no move, never blocked
		endcase
	end

	// same chase direction the enemy unit uses
	assign ex_next = (enemy_x < player_x) ? enemy_x + 1'b1
		: (enemy_x > player_x) ? enemy_x - 1'b1 : enemy_x;
	assign ey_next = (enemy_y < player_y) ? enemy_y + 1'b1
		: (enemy_y > player_y) ? enemy_y - 1'b1 : enemy_y;

	assign dx = (enemy_x > player_x) ? enemy_x - player_x : player_x - enemy_x;
	assign dy = (enemy_y > player_y) ? enemy_y - player_y : player_y - enemy_y;

	// reach of 2 along the facing axis, 1 across it
	assign in_reach = (facing == act_up || facing == act_down)
		? (dy <= 2 && dx <= 1) : (dx <= 2 && dy <= 1);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			player_blocked <= 1'b0;
			enemy_block_x <= 1'b0;
			enemy_block_y <= 1'b0;
			attack_hit <= 1'b0;
		end
		else if (check_collide) // held until the next frame's check
		begin
			player_blocked <= hits_wall(px_next, py_next);
			enemy_block_x <= hits_wall(ex_next, enemy_y);
			enemy_block_y <= hits_wall(enemy_x, ey_next);
			attack_hit <= (action == act_attack) && in_reach;
		end
	end

endmodule

`default_nettype wire

// File: hdl/pixel_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module pixel_arbiter import game_pkg::*;
(
	input logic map_req,
	input logic [x_width-1:0] map_x,
	input logic [y_width-1:0] map_y,
	input colour_t map_colour,
	input logic ply_req,
	input logic [x_width-1:0] ply_x,
	input logic [y_width-1:0] ply_y,
	input colour_t ply_colour,
	input logic enm_req,
	input logic [x_width-1:0] enm_x,
	input logic [y_width-1:0] enm_y,
	input colour_t enm_colour,
	output logic map_grant,
	output logic ply_grant,
	output logic enm_grant,
	output logic [x_width-1:0] x_position,
	output logic [y_width-1:0] y_position,
	output colour_t colour,
	output logic vga_enable
);

	// fixed priority map > player > enemy
	assign map_grant = map_req;
	assign ply_grant = ply_req && !map_req;
	assign enm_grant = enm_req && !map_req && !ply_req;
	assign vga_enable = map_req || ply_req || enm_req; // same cycle as the grant

	always_comb
	begin
		x_position = '0; // quiet bus between writes
		y_position = '0;
		colour = '0;
		if (map_grant)
		begin
			x_position = map_x;
			y_position = map_y;
			colour = map_colour;
		end
		else if (ply_grant)
		begin
			x_position = ply_x;
			y_position = ply_y;
			colour = ply_colour;
		end
		else if (enm_grant)
		begin
			x_position = enm_x;
			y_position = enm_y;
			colour = enm_colour;
		end
	end

	// sequencer runs one draw phase at a time, so no drawer is ever stalled
	always_comb
	begin
		assert final ($onehot0({map_req, ply_req, enm_req}));
	end

endmodule

`default_nettype wire

// File: hdl/game_datapath.sv
`timescale 1ns/10ps
`default_nettype none

module game_datapath import game_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic c_attack,
	input logic c_up,
	input logic c_down,
	input logic c_left,
	input logic c_right,
	output logic [x_width-1:0] x_position, // to the frame buffer
	output logic [y_width-1:0] y_position,
	output colour_t colour,
	output logic vga_enable,
	output logic [x_width-1:0] player_x, // status display
	output logic [y_width-1:0] player_y,
	output logic [7:0] score
);

	// phase strobes and their done handshakes
	logic init, idle, gen_move, check_collide, apply_action, move_enemy;
	logic draw_map, draw_player, draw_enemy;
	logic idle_done, map_done, player_done, enemy_done;

	action_t action, facing;
	logic [x_width-1:0] enemy_x;
	logic [y_width-1:0] enemy_y;
	logic player_blocked, enemy_block_x, enemy_block_y, attack_hit;

	// drawer ports into the arbiter
	logic map_req, ply_req, enm_req;
	logic map_grant, ply_grant, enm_grant;
	logic [x_width-1:0] map_x, ply_x, enm_x;
	logic [y_width-1:0] map_y, ply_y, enm_y;
	colour_t map_colour, ply_colour, enm_colour;

	game_control i_control (.*);
	frame_timer i_timer (.*);
	collision_detector i_collide (.*);
	pixel_arbiter i_arbiter (.*);

	map_drawer i_map (.clock, .reset, .draw_map, .grant(map_grant), .req(map_req),
		.x(map_x), .y(map_y), .colour(map_colour), .map_done);

	player_unit i_player (.*, .grant(ply_grant), .req(ply_req), .x(ply_x), .y(ply_y),
		.colour(ply_colour));

	enemy_unit i_enemy (.*, .grant(enm_grant), .req(enm_req), .x(enm_x), .y(enm_y),
		.colour(enm_colour));

endmodule

`default_nettype wire

// File: dv/game_tb.sv
`timescale 1ns/10ps
`default_nettype none

module game_tb import game_pkg::*;
();

	localparam int frame_writes = 200; // 192 map + 4 player + 4 enemy
	localparam int max_frames = 110; // all tests with the attack search at its longest
	localparam int watchdog_cycles = max_frames * 400;

	logic clock;
	logic reset;
	logic c_attack, c_up, c_down, c_left, c_right;
	logic [x_width-1:0] x_position;
	logic [y_width-1:0] y_position;
	colour_t colour;
	logic vga_enable;
	logic [x_width-1:0] player_x;
	logic [y_width-1:0] player_y;
	logic [7:0] score;

	int wr; // write index within the frame
	int frames;
	int writes_total;
	int since_reset; // cycles since reset went low
	int errors;
	int test_errors;
	int test_frames;
	int n;

	// reference model state after the current frame's moves
	int m_px, m_py, m_ex, m_ey, m_score;
	action_t m_facing;

	int exp_x, exp_y; // expected pixel write
	colour_t exp_colour;
	logic in_reset_test;

	game_datapath i_dut (.*);

	initial
	begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	function automatic void report_mismatch(string name, int got, int expected);
		errors++;
		$display("CHECK FAILED t=%0t %s got %0d expected %0d", $time, name, got, expected);
	endfunction

	function automatic void report_problem(string msg);
		errors++;
		$display("ERROR t=%0t %s", $time, msg);
	endfunction

	function automatic logic on_floor(int sx, int sy); // whole sprite clear of the wall
		return sx >= 1 && sx <= field_w - sprite_size - 1
			&& sy >= 1 && sy <= field_h - sprite_size - 1;
	endfunction

	function automatic int toward(int from, int to);
		return (from < to) ? 1 : (from > to) ? -1 : 0;
	endfunction

	function automatic logic enemy_in_reach();
		int dx;
		int dy;
		dx = (m_ex > m_px) ? m_ex - m_px : m_px - m_ex;
		dy = (m_ey > m_py) ? m_ey - m_py : m_py - m_ey;
		if (m_facing == act_up || m_facing == act_down)
			return dy <= 2 && dx <= 1; // long reach along the facing axis
		return dx <= 2 && dy <= 1;
	endfunction

	// btn is {attack, up, down, left, right}
	task automatic advance_model(input logic [4:0] btn);
		action_t act;
		int nx;
		int ny;
		logic hit;
		act = btn[4] ? act_attack : btn[3] ? act_up : btn[2] ? act_down
			: btn[1] ? act_left : btn[0] ? act_right : act_none;
		if (act != act_none && act != act_attack)
			m_facing = act;
		hit = (act == act_attack) && enemy_in_reach(); // positions before the move
		nx = m_px + ((act == act_right) ? 1 : 0) - ((act == act_left) ? 1 : 0);
		ny = m_py + ((act == act_down) ? 1 : 0) - ((act == act_up) ? 1 : 0);
		if (on_floor(nx, ny))
		begin
			m_px = nx;
			m_py = ny;
		end
		if (hit && m_score < 255)
			m_score++;
		if (hit)
		begin
			m_ex = enemy_start_x; // respawn
			m_ey = enemy_start_y;
		end
		else if (m_ex != m_px && on_floor(m_ex + toward(m_ex, m_px), m_ey))
			m_ex += toward(m_ex, m_px); // chase the moved player in x first
		else if (m_ey != m_py && on_floor(m_ex, m_ey + toward(m_ey, m_py)))
			m_ey += toward(m_ey, m_py);
	endtask

	// buttons change right after a frame's last write and long before gen_move
	task automatic play_frame(input logic [4:0] btn);
		int target;
		@(negedge clock);
		{c_attack, c_up, c_down, c_left, c_right} = btn;
		advance_model(btn);
		target = frames + 1;
		while (frames < target)
			@(posedge clock);
		test_frames++;
	endtask

	task automatic summarize_test(string name);
		$display("test %s: %0d frames, %0d errors", name, test_frames, errors - test_errors);
		test_errors = errors;
		test_frames = 0;
	endtask

	always @(posedge clock)
	begin
		if (reset)
		begin
			wr <= 0;
			frames <= 0;
			since_reset <= 0;
		end
		else
		begin
			since_reset <= since_reset + 1;
			if (vga_enable)
			begin
				writes_total <= writes_total + 1;
				wr <= (wr == frame_writes - 1) ? 0 : wr + 1; // frame boundary
				if (wr == frame_writes - 1)
					frames <= frames + 1;
			end
		end
	end

	always_comb
	begin
		if (wr < field_w * field_h)
		begin
			exp_x = wr % field_w; // raster order
			exp_y = wr / field_w;
			exp_colour = (exp_x == 0 || exp_y == 0 || exp_x == field_w - 1
				|| exp_y == field_h - 1) ? wall_colour : floor_colour;
		end
		else if (wr < field_w * field_h + 4)
		begin
			exp_x = m_px + (wr & 1);
			exp_y = m_py + ((wr - field_w * field_h) >> 1);
			exp_colour = player_colour;
		end
		else
		begin
			exp_x = m_ex + (wr & 1);
			exp_y = m_ey + ((wr - field_w * field_h - 4) >> 1);
			exp_colour = enemy_colour;
		end
	end

	assign in_reset_test = since_reset < 60; // well before the first map write

	assert property (@(posedge clock) disable iff (reset) in_reset_test |-> !vga_enable)
		else report_problem("vga_enable went high straight after reset");
	assert property (@(posedge clock) disable iff (reset)
		vga_enable |-> x_position < field_w && y_position < field_h)
		else report_problem("pixel write landed outside the field");
	assert property (@(posedge clock) disable iff (reset) vga_enable |-> x_position == exp_x)
		else report_mismatch("x_position", $sampled(x_position), $sampled(exp_x));
	assert property (@(posedge clock) disable iff (reset) vga_enable |-> y_position == exp_y)
		else report_mismatch("y_position", $sampled(y_position), $sampled(exp_y));
	assert property (@(posedge clock) disable iff (reset) vga_enable |-> colour == exp_colour)
		else report_mismatch("colour", $sampled(colour), $sampled(exp_colour));
	// status outputs checked while drawing and right after reset
	assert property (@(posedge clock) disable iff (reset)
		(vga_enable || in_reset_test) |-> player_x == m_px)
		else report_mismatch("player_x", $sampled(player_x), $sampled(m_px));
	assert property (@(posedge clock) disable iff (reset)
		(vga_enable || in_reset_test) |-> player_y == m_py)
		else report_mismatch("player_y", $sampled(player_y), $sampled(m_py));
	assert property (@(posedge clock) disable iff (reset)
		(vga_enable || in_reset_test) |-> score == m_score)
		else report_mismatch("score", $sampled(score), $sampled(m_score));

	initial
	begin
		repeat (watchdog_cycles) @(posedge clock);
		$display("ERROR watchdog expired after %0d cycles, the design stopped drawing",
			watchdog_cycles);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial
	begin
		void'($urandom(32'h1819796f));
		{reset, c_attack, c_up, c_down, c_left, c_right} = 6'b100000;
		errors = 0;
		test_errors = 0;
		test_frames = 0;
		writes_total = 0;
		m_px = player_start_x;
		m_py = player_start_y;
		m_ex = enemy_start_x;
		m_ey = enemy_start_y;
		m_score = 0;
		m_facing = act_down; // design resets facing down
		repeat (2) @(negedge clock);
		reset = 1'b0;

		play_frame(5'b00000); // reset window checks run during this frame
		summarize_test("reset");
		play_frame(5'b00000);
		summarize_test("map");

		repeat (4) play_frame(5'b00000); // enemy still far off and closing in x
		summarize_test("enemy_chase");

		repeat (14) play_frame(5'b00001); // right into the wall
		repeat (10) play_frame(5'b00100); // down into the wall
		repeat (2) play_frame(5'b01111); // up wins over the rest
		repeat (2) play_frame(5'b00011); // left over right
		summarize_test("player_move");

		n = 0;
		while (!enemy_in_reach() && n < 30)
		begin
			play_frame(5'b00000); // let the enemy close in
			n++;
		end
		if (enemy_in_reach())
			play_frame(5'b10000);
		else
			report_problem("enemy never came within attack reach");
		summarize_test("attack");

		repeat (40) play_frame(5'($urandom));
		summarize_test("random_play");

		$display("tests 6, frames %0d, pixel writes %0d, errors %0d", frames, writes_total,
			errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
hdl/game_pkg.sv
hdl/game_control.sv
hdl/frame_timer.sv
hdl/map_drawer.sv
hdl/player_unit.sv
hdl/enemy_unit.sv
hdl/collision_detector.sv
hdl/pixel_arbiter.sv
hdl/game_datapath.sv
dv/game_tb.sv

// File: run.sh
#!/bin/sh
# build and run the game testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module game_tb -o game_sim

./obj_dir/game_sim | tee sim.log

# a missing pass line fails the script
grep -q "\*\*\* TEST PASSED \*\*\*" sim.log
echo "simulation passed"
